// File: ext_mem.f
+incdir+.
ext_mem_pkg.sv
l1_cache.sv
bus_merge.sv
ext_mem.sv
tb_mem_model.sv
tb_ext_mem.sv

// File: tb_ext_mem.sv
`include "ext_mem_macros.svh"

module tb_ext_mem;

   import ext_mem_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   localparam int DRIVE_DELAY  = 2;
   localparam int NUM_ENTRIES  = 22;
   localparam int HIT_CYCLES   = 2; // Valid sampled at one edge, ready at the next
   localparam int LINE_LSB     = `EXT_MEM_WORD_OFF_W + `EXT_MEM_BYTE_OFF_W;
   localparam int FILL_WORDS   = 1 << `EXT_MEM_WORD_OFF_W;
   localparam int MEM_WORDS    = 1 << (`EXT_MEM_ADDR_W - 2);

   typedef enum logic { PORT_I, PORT_D } port_t;

   typedef struct packed {
      port_t                      port;
      logic                       wr;
      logic [`EXT_MEM_ADDR_W-1:0] addr;
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      logic [`EXT_MEM_STRB_W-1:0] wstrb;
      logic                       miss;  // Read expected to fill a line
      logic                       joint; // Issued together with the next entry
   } entry_t;

   logic      clk;
   logic      rst;
   mem_req_t  i_req;
   mem_resp_t i_resp;
   mem_req_t  d_req;
   mem_resp_t d_resp;
   mem_req_t  mem_req;
   mem_resp_t mem_resp;

   entry_t                     stim [NUM_ENTRIES];
   logic [`EXT_MEM_DATA_W-1:0] shadow [MEM_WORDS];
   mem_req_t                   seen_q [$]; // Completed back-end transactions
   mem_resp_t                  got [2];
   int                         cycles [2];
   bit                         group_ok;
   int                         passes;
   int                         fails;

   ext_mem UUT (
      .clk      (clk),
      .rst      (rst),
      .i_req    (i_req),
      .i_resp   (i_resp),
      .d_req    (d_req),
      .d_resp   (d_resp),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   tb_mem_model mem_model (.clk(clk), .rst(rst), .req(mem_req), .resp(mem_resp));

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) begin
      if (!rst && mem_req.valid && mem_resp.ready)
         seen_q.push_back(mem_req);
   end

   // Worst case is a four-word fill per entry
   initial begin
      repeat (RESET_CYCLES + NUM_ENTRIES * (4 * 5 + 10)) @(posedge clk);
      $display("Timeout: the DUT did not finish all table entries in time");
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic entry_t make_entry(input port_t port, input logic wr,
         input logic [`EXT_MEM_ADDR_W-1:0] addr, input logic [`EXT_MEM_DATA_W-1:0] wdata,
         input logic [`EXT_MEM_STRB_W-1:0] wstrb, input logic miss, input logic joint);
      entry_t e;
      e = '{port: port, wr: wr, addr: addr, wdata: wdata, wstrb: wstrb,
            miss: miss, joint: joint};
      return e;
   endfunction

   task automatic load_table();
      stim[0]  = make_entry(PORT_I, 0, 16'h0100, 32'h0, 4'h0, 1, 0); // Cold instruction read
      stim[1]  = make_entry(PORT_D, 0, 16'h0204, 32'h0, 4'h0, 1, 0); // Cold data read
      stim[2]  = make_entry(PORT_I, 0, 16'h0108, 32'h0, 4'h0, 0, 0);
      stim[3]  = make_entry(PORT_D, 0, 16'h020c, 32'h0, 4'h0, 0, 0);
      stim[4]  = make_entry(PORT_D, 1, 16'h0208, 32'ha5a5_1234, 4'hf, 0, 0); // Write hit
      stim[5]  = make_entry(PORT_D, 0, 16'h0208, 32'h0, 4'h0, 0, 0);
      stim[6]  = make_entry(PORT_D, 1, 16'h0210, 32'hdead_beef, 4'h5, 0, 0); // Write miss
      stim[7]  = make_entry(PORT_D, 0, 16'h0210, 32'h0, 4'h0, 1, 0);
      stim[8]  = make_entry(PORT_D, 1, 16'h0214, 32'h1122_3344, 4'h8, 0, 0);
      stim[9]  = make_entry(PORT_D, 0, 16'h0214, 32'h0, 4'h0, 0, 0);
      stim[10] = make_entry(PORT_I, 0, 16'h0130, 32'h0, 4'h0, 1, 1); // Both ports miss
      stim[11] = make_entry(PORT_D, 0, 16'h0344, 32'h0, 4'h0, 1, 0);
      stim[12] = make_entry(PORT_I, 0, 16'h0134, 32'h0, 4'h0, 0, 1);
      stim[13] = make_entry(PORT_D, 0, 16'h0348, 32'h0, 4'h0, 0, 0);
      stim[14] = make_entry(PORT_D, 0, 16'h1204, 32'h0, 4'h0, 1, 0); // Evicts line 0x0200
      stim[15] = make_entry(PORT_D, 0, 16'h0208, 32'h0, 4'h0, 1, 0);
      stim[16] = make_entry(PORT_I, 0, 16'h0150, 32'h0, 4'h0, 1, 1);
      stim[17] = make_entry(PORT_D, 1, 16'h0460, 32'h0bad_cafe, 4'h3, 0, 0);
      stim[18] = make_entry(PORT_I, 0, 16'h0164, 32'h0, 4'h0, 1, 1);
      stim[19] = make_entry(PORT_D, 0, 16'h0464, 32'h0, 4'h0, 1, 0);
      stim[20] = make_entry(PORT_D, 0, 16'h0460, 32'h0, 4'h0, 0, 0);
      stim[21] = make_entry(PORT_I, 0, 16'h0100, 32'h0, 4'h0, 0, 0);
   endtask

   task automatic check_resp(input string name, input mem_resp_t got_resp,
                             input logic [`EXT_MEM_DATA_W-1:0] exp_rdata);
      if (got_resp.rdata !== exp_rdata) begin
         $display("MISMATCH %s.rdata: got %h, expected %h", name, got_resp.rdata, exp_rdata);
         group_ok = 1'b0;
      end
   endtask

   task automatic check_req(input mem_req_t got_req, input mem_req_t exp_req);
      if (got_req.addr !== exp_req.addr || got_req.wstrb !== exp_req.wstrb ||
          (exp_req.wstrb != '0 && got_req.wdata !== exp_req.wdata)) begin
         $display("MISMATCH mem_req addr/wdata/wstrb: got %h/%h/%h, expected %h/%h/%h",
                  got_req.addr, got_req.wdata, got_req.wstrb,
                  exp_req.addr, exp_req.wdata, exp_req.wstrb);
         group_ok = 1'b0;
      end
   endtask

   task automatic check_count(input string name, input int got_n, input int exp_n);
      if (got_n != exp_n) begin
         $display("MISMATCH %s: got %h, expected %h", name, got_n, exp_n);
         group_ok = 1'b0;
      end
   endtask

   task automatic check_flag(input string name, input logic got_bit, input logic exp_bit);
      if (got_bit !== exp_bit) begin
         $display("MISMATCH %s: got %h, expected %h", name, got_bit, exp_bit);
         group_ok = 1'b0;
      end
   endtask

   // Holds the request until the port answers
   task automatic run_access(input entry_t e, output mem_resp_t fe_resp, output int n_cycles);
      mem_req_t r;
      r       = '0;
      r.valid = 1'b1;
      r.addr  = e.addr;
      if (e.wr) begin
         r.wdata = e.wdata;
         r.wstrb = e.wstrb;
      end
      if (e.port == PORT_I)
         i_req = r;
      else
         d_req = r;
      n_cycles = 0;
      do begin
         @(posedge clk);
         n_cycles++;
         fe_resp = (e.port == PORT_I) ? i_resp : d_resp;
      end while (!fe_resp.ready);
      #DRIVE_DELAY;
      if (e.port == PORT_I)
         i_req = '0;
      else
         d_req = '0;
   endtask

   task automatic check_group(input int first, input int n);
      entry_t   e;
      mem_req_t exp_req;
      int       exp_reads;
      int       exp_writes;
      int       n_reads;
      int       n_writes;
      int       k;
      exp_reads  = 0;
      exp_writes = 0;
      n_reads    = 0;
      n_writes   = 0;
      foreach (seen_q[j]) begin
         if (seen_q[j].wstrb == '0)
            n_reads++;
         else
            n_writes++;
      end
      for (int s = 0; s < n; s++) begin
         if (stim[first + s].wr)
            exp_writes++;
         else if (stim[first + s].miss)
            exp_reads += FILL_WORDS;
      end
      check_count("backend reads", n_reads, exp_reads);
      check_count("backend writes", n_writes, exp_writes);
      for (int s = 0; s < n; s++) begin
         e             = stim[first + s];
         exp_req       = '0;
         exp_req.valid = 1'b1;
         if (e.wr) begin
            exp_req.addr  = e.addr;
            exp_req.wdata = e.wdata;
            exp_req.wstrb = e.wstrb;
            foreach (seen_q[j]) begin
               if (seen_q[j].wstrb != '0)
                  check_req(seen_q[j], exp_req);
            end
            for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
               if (e.wstrb[b])
                  shadow[e.addr >> 2][8*b +: 8] = e.wdata[8*b +: 8];
            end
         end else begin
            check_resp(e.port == PORT_I ? "i_resp" : "d_resp", got[s], shadow[e.addr >> 2]);
            if (e.miss) begin
               k = 0;
               // Fill words of this line in issue order
               foreach (seen_q[j]) begin
                  if (seen_q[j].wstrb == '0 &&
                      seen_q[j].addr[`EXT_MEM_ADDR_W-1:LINE_LSB] ==
                      e.addr[`EXT_MEM_ADDR_W-1:LINE_LSB]) begin
                     exp_req.addr = {e.addr[`EXT_MEM_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}}
                                    + 4 * k;
                     check_req(seen_q[j], exp_req);
                     k++;
                  end
               end
               check_count("line fill reads", k, FILL_WORDS);
            end else begin
               check_count("hit latency in cycles", cycles[s], HIT_CYCLES);
            end
         end
      end
   endtask

   task automatic report(input string what);
      if (group_ok) begin
         passes++;
         $display("%s: ok", what);
      end else begin
         fails++;
         $display("%s: FAIL", what);
      end
   endtask

   initial begin
      int idx;
      int n;
      passes = 0;
      fails  = 0;
      rst    = 1'b1;
      i_req  = '0;
      d_req  = '0;
      load_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst    = 1'b0;
      shadow = mem_model.mem; // Memory starts with the model's contents
      group_ok = 1'b1;
      check_flag("mem_req.valid", mem_req.valid, 1'b0);
      check_flag("i_resp.ready", i_resp.ready, 1'b0);
      check_flag("d_resp.ready", d_resp.ready, 1'b0);
      report("Reset state");
      idx = 0;
      while (idx < NUM_ENTRIES) begin
         n        = stim[idx].joint ? 2 : 1;
         group_ok = 1'b1;
         seen_q.delete();
         fork
            run_access(stim[idx], got[0], cycles[0]);
            if (n == 2)
               run_access(stim[idx + 1], got[1], cycles[1]);
         join
         check_group(idx, n);
         for (int s = 0; s < n; s++) begin
            report($sformatf("Entry %0d %s %s at %h", idx + s,
                             stim[idx + s].port == PORT_I ? "I" : "D",
                             stim[idx + s].wr ? "write" : "read", stim[idx + s].addr));
         end
         idx += n;
         @(posedge clk); // One idle cycle between entries
         #DRIVE_DELAY;
      end
      $display("Tests: %0d passed, %0d failed", passes, fails);
      if (fails == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: tb_mem_model.sv
`include "ext_mem_macros.svh"

module tb_mem_model (
   input  logic                   clk,
   input  logic                   rst,
   input  ext_mem_pkg::mem_req_t  req,
   output ext_mem_pkg::mem_resp_t resp
);

   localparam int WORDS = 1 << (`EXT_MEM_ADDR_W - 2);

   logic [`EXT_MEM_DATA_W-1:0]   mem [WORDS];
   logic [`EXT_MEM_ADDR_W-3:0]   widx;     // Word index of the request
   integer                       seed;
   integer                       draw;
   logic                         busy;     // Request accepted, latency running
   logic [1:0]                   wait_cnt;

   assign widx = req.addr[`EXT_MEM_ADDR_W-1:2];

   initial begin
      seed = 32'h6cd8;
      resp = '0;
      for (int i = 0; i < WORDS; i++)
         mem[i] = $random(seed) ^ i; // Random contents, distinct per word
   end

   always @(posedge clk) begin
      if (rst) begin
         resp     <= '0;
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (resp.ready) begin
         resp.ready <= 1'b0; // Request retires at this edge
      end else if (req.valid) begin
         if (!busy) begin
            draw     = $random(seed);
            wait_cnt <= draw[1:0]; // One to four cycles until ready
            busy     <= 1'b1;
         end else if (wait_cnt == 0) begin
            busy       <= 1'b0;
            resp.ready <= 1'b1;
            resp.rdata <= mem[widx];
            for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
               if (req.wstrb[b])
                  mem[widx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end else begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

endmodule

// File: ext_mem.sv
module ext_mem (
   input  logic                   clk,
   input  logic                   rst,

   // Instruction port, reads only
   input  ext_mem_pkg::mem_req_t  i_req,
   output ext_mem_pkg::mem_resp_t i_resp,

   // Data port
   input  ext_mem_pkg::mem_req_t  d_req,
   output ext_mem_pkg::mem_resp_t d_resp,

   // External memory
   output ext_mem_pkg::mem_req_t  mem_req,
   input  ext_mem_pkg::mem_resp_t mem_resp
);

   import ext_mem_pkg::*;

   // Cache back-ends into the merge
   mem_req_t  icache_be_req;
   mem_resp_t icache_be_resp;
   mem_req_t  dcache_be_req;
   mem_resp_t dcache_be_resp;

   l1_cache icache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (icache_be_req),
      .be_resp (icache_be_resp)
   );

   l1_cache dcache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (dcache_be_req),
      .be_resp (dcache_be_resp)
   );

   // Data cache is master 1 and wins ties
   bus_merge cache_merge (
      .clk     (clk),
      .rst     (rst),
      .m0_req  (icache_be_req),
      .m0_resp (icache_be_resp),
      .m1_req  (dcache_be_req),
      .m1_resp (dcache_be_resp),
      .s_req   (mem_req),
      .s_resp  (mem_resp)
   );

endmodule

// File: bus_merge.sv
module bus_merge (
   input  logic                   clk,
   input  logic                   rst,

   // Master 0, instruction side
   input  ext_mem_pkg::mem_req_t  m0_req,
   output ext_mem_pkg::mem_resp_t m0_resp,

   // Master 1, data side
   input  ext_mem_pkg::mem_req_t  m1_req,
   output ext_mem_pkg::mem_resp_t m1_resp,

   // Shared slave
   output ext_mem_pkg::mem_req_t  s_req,
   input  ext_mem_pkg::mem_resp_t s_resp
);

   logic busy;  // Slave request pending
   logic grant; // Owner while busy (1 is master 1)
   logic sel;

   // Data master wins a tie when idle
   assign sel = busy ? grant : m1_req.valid;

   assign s_req = sel ? m1_req : m0_req;

   always_comb begin
      m0_resp.rdata = s_resp.rdata;
      m0_resp.ready = s_resp.ready && !sel;
      m1_resp.rdata = s_resp.rdata;
      m1_resp.ready = s_resp.ready && sel; // Loser sees ready low
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy  <= 1'b0;
         grant <= 1'b0;
      end else if (!busy) begin
         // Lock the choice if the slave does not answer at once
         if (s_req.valid && !s_resp.ready) begin
            busy  <= 1'b1;
            grant <= sel;
         end
      end else if (s_resp.ready) begin
         busy <= 1'b0; // Free to rearbitrate next cycle
      end
   end

   // Slave sees one steady request until it answers
   a_grant_hold: assert property (@(posedge clk) disable iff (rst)
      s_req.valid && !s_resp.ready |=> $stable(s_req));

   // Memory only answers a live request
   a_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
      s_resp.ready |-> s_req.valid);

endmodule

// File: l1_cache.sv
`include "ext_mem_macros.svh"

module l1_cache (
   input  logic                   clk,
   input  logic                   rst,

   // Front-end, toward the processor
   input  ext_mem_pkg::mem_req_t  fe_req,
   output ext_mem_pkg::mem_resp_t fe_resp,

   // Back-end, toward memory
   output ext_mem_pkg::mem_req_t  be_req,
   input  ext_mem_pkg::mem_resp_t be_resp
);

   import ext_mem_pkg::*;

   localparam int LINES = 1 << `EXT_MEM_LINE_OFF_W;
   localparam int WORDS = 1 << `EXT_MEM_WORD_OFF_W;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_FILL,
      S_WRITE,
      S_RESPOND
   } state_t;

   state_t                          state;

   // Latched front-end request
   cache_addr_u                     req_addr;
   logic [`EXT_MEM_DATA_W-1:0]      req_wdata;
   logic [`EXT_MEM_STRB_W-1:0]      req_wstrb;

   logic [`EXT_MEM_WORD_OFF_W-1:0]  fill_cnt; // Word being fetched

   logic [LINES-1:0]                valid_arr;
   logic [`EXT_MEM_TAG_W-1:0]       tag_arr  [LINES];
   logic [`EXT_MEM_DATA_W-1:0]      data_arr [LINES][WORDS];

   logic                            is_write;
   logic                            hit;
   logic                            fill_last;
   logic [`EXT_MEM_DATA_W-1:0]      rd_word;

   assign is_write  = |req_wstrb;
   assign hit       = valid_arr[req_addr.fields.index] &&
                      (tag_arr[req_addr.fields.index] == req_addr.fields.tag);
   assign fill_last = &fill_cnt;
   assign rd_word   = data_arr[req_addr.fields.index][req_addr.fields.word];

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         fill_cnt  <= '0;
         valid_arr <= '0; // Every line starts invalid
      end else begin
         case (state)
            S_IDLE: begin
               if (fe_req.valid)
                  state <= S_LOOKUP;
            end
            S_LOOKUP: begin
               if (is_write) begin
                  state <= S_WRITE; // No allocate, write goes straight through
               end else if (hit) begin
                  state <= S_IDLE;
               end else begin
                  state    <= S_FILL;
                  fill_cnt <= '0;
               end
            end
            S_FILL: begin
               if (be_resp.ready) begin
                  fill_cnt <= fill_cnt + 1'b1;
                  if (fill_last) begin
                     valid_arr[req_addr.fields.index] <= 1'b1;
                     state                            <= S_RESPOND;
                  end
               end
            end
            S_WRITE: begin
               if (be_resp.ready)
                  state <= S_RESPOND;
            end
            S_RESPOND: state <= S_IDLE;
            default:   state <= S_IDLE;
         endcase
      end
   end

   // Request latch, tag and data arrays
   always_ff @(posedge clk) begin
      if (state == S_IDLE && fe_req.valid) begin
         req_addr.flat <= fe_req.addr;
         req_wdata     <= fe_req.wdata;
         req_wstrb     <= fe_req.wstrb;
      end
      if (state == S_FILL && be_resp.ready) begin
         data_arr[req_addr.fields.index][fill_cnt] <= be_resp.rdata;
         if (fill_last)
            tag_arr[req_addr.fields.index] <= req_addr.fields.tag;
      end
      // Keep a cached line in step with memory
      if (state == S_WRITE && be_resp.ready && hit) begin
         for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
            if (req_wstrb[b])
               data_arr[req_addr.fields.index][req_addr.fields.word][8*b +: 8] <=
                  req_wdata[8*b +: 8];
         end
      end
   end

   always_comb begin
      be_req = '0;
      if (state == S_FILL) begin
         be_req.valid = 1'b1;
         be_req.addr  = {req_addr.fields.tag, req_addr.fields.index, fill_cnt,
                         {`EXT_MEM_BYTE_OFF_W{1'b0}}};
      end else if (state == S_WRITE) begin
         be_req.valid = 1'b1;
         be_req.addr  = req_addr.flat;
         be_req.wdata = req_wdata;
         be_req.wstrb = req_wstrb;
      end
   end

   always_comb begin
      fe_resp.rdata = rd_word;
      fe_resp.ready = (state == S_RESPOND) ||
                      (state == S_LOOKUP && hit && !is_write); // Hit answers here
   end

   // Back-end request held until memory accepts it
   a_be_stable: assert property (@(posedge clk) disable iff (rst)
      be_req.valid && !be_resp.ready |=> $stable(be_req));

   // One answer per accepted request
   a_fe_ready_pulse: assert property (@(posedge clk) disable iff (rst)
      fe_resp.ready |=> !fe_resp.ready);

endmodule

// File: ext_mem_pkg.sv
`include "ext_mem_macros.svh"

package ext_mem_pkg;

   // Native bus request, driven by the master
   typedef struct packed {
      logic                       valid;
      logic [`EXT_MEM_ADDR_W-1:0] addr;
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      logic [`EXT_MEM_STRB_W-1:0] wstrb; // All zero for a read
   } mem_req_t;

   // Native bus response, driven by the slave
   typedef struct packed {
      logic [`EXT_MEM_DATA_W-1:0] rdata;
      logic                       ready; // Single-cycle pulse
   } mem_resp_t;

   // Byte address as seen by a direct-mapped cache
   typedef struct packed {
      logic [`EXT_MEM_TAG_W-1:0]      tag;
      logic [`EXT_MEM_LINE_OFF_W-1:0] index;
      logic [`EXT_MEM_WORD_OFF_W-1:0] word;
      logic [`EXT_MEM_BYTE_OFF_W-1:0] byte_off;
   } cache_addr_fields_t;

   // Written as a flat address, read back through the fields
   typedef union packed {
      logic [`EXT_MEM_ADDR_W-1:0] flat;
      cache_addr_fields_t         fields;
   } cache_addr_u;

endpackage

// File: ext_mem_macros.svh
`ifndef EXT_MEM_MACROS_SVH
`define EXT_MEM_MACROS_SVH

// Native bus widths
`define EXT_MEM_ADDR_W 16 // Byte address
`define EXT_MEM_DATA_W 32
`define EXT_MEM_STRB_W (`EXT_MEM_DATA_W/8) // One strobe per byte

// Cache address split, from the top bit down
`define EXT_MEM_TAG_W 8
`define EXT_MEM_LINE_OFF_W 4 // Sixteen lines
`define EXT_MEM_WORD_OFF_W 2 // Four words per line
`define EXT_MEM_BYTE_OFF_W 2

`endif
